//--- design/cp0_settings.svh
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

// Processor identification, read-only through the APB port
`define CP0_PRID 32'h0000_8020

// Single handler entry point for interrupts and errors alike
`define CP0_EXC_VECTOR 32'h0000_4180

// Status after reset
// EXL and IE both clear
`define CP0_SR_RESET 32'h0000_0000

// Register number width on paddr
`define CP0_ADDR_W 5

`endif

//--- design/cp0RegPkg.sv
`include "cp0_settings.svh"

`default_nettype none

package cp0RegPkg;

	// One architectural register value
	typedef logic [31:0] cp0Word;

	// Register number as carried on paddr
	typedef logic [`CP0_ADDR_W-1:0] cp0RegAddr;

	// Implemented register numbers
	typedef enum cp0RegAddr
	{
		srReg    = 5'd12,
		causeReg = 5'd13,
		epcReg   = 5'd14,
		pridReg  = 5'd15
	} cp0RegSel;

	// ExcCode field of Cause
	// Error codes from the pipeline go through as they are
	typedef enum logic [4:0]
	{
		intExc  = 5'd0,
		adelExc = 5'd4,
		adesExc = 5'd5,
		sysExc  = 5'd8,
		riExc   = 5'd10,
		ovExc   = 5'd12,
		noExc   = 5'd31
	} excCode;

	// Hardware interrupt lines, numbered as in Cause.IP
	typedef logic [7:2] hwIntVec;

	// Register write strobe from the bus port
	typedef struct packed
	{
		logic      valid;
		cp0RegAddr addr;
		cp0Word    data;
	} cp0Write;

endpackage

`default_nettype wire

//--- design/pipeRetirePkg.sv
`default_nettype none

package pipeRetirePkg;

	import cp0RegPkg::*;

	// Control flow class of the retiring instruction
	typedef enum logic [1:0]
	{
		plainOp  = 2'd0,
		jumpOp   = 2'd1,
		branchOp = 2'd2,
		eretOp   = 2'd3
	} instrClass;

	// Program counter
	typedef logic [31:0] virtAddr;

	// Report from writeback for each retiring instruction
	typedef struct packed
	{
		logic      valid;
		virtAddr   pc;
		instrClass cls;
		logic      err;
		excCode    errCode;
	} retireInfo;

	// Exception decision plus victim info for the register bank
	typedef struct packed
	{
		logic    take;
		excCode  code;
		virtAddr epc;
		logic    bd;
	} excRequest;

	// New fetch address
	typedef struct packed
	{
		logic    valid;
		virtAddr pc;
	} redirect;

endpackage

`default_nettype wire

//--- design/delaySlotTracker.sv
`default_nettype none

module delaySlotTracker
	import pipeRetirePkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  retireInfo retire,
	output virtAddr   victimEpc,
	output logic      inDelaySlot
);

	//////////////////////////////////////////////////////////////////////
	// Control transfer history
	//////////////////////////////////////////////////////////////////////

	// Set when the last valid retire was a jump or branch
	logic prevCtl;

	// Current retire is itself a control transfer
	logic isCtl;

	// Word aligned retire pc
	virtAddr alignedPc;

	assign isCtl = (retire.cls == jumpOp) || (retire.cls == branchOp);

	always_ff @(posedge clk)
	begin
		if (reset)
			prevCtl <= 1'b0;
		// Bubbles leave the history alone
		else if (retire.valid)
			prevCtl <= isCtl;
	end

	//////////////////////////////////////////////////////////////////////
	// Victim pc
	//////////////////////////////////////////////////////////////////////

	assign alignedPc = {retire.pc[31:2], 2'b00};

	// Instruction in a delay slot restarts at its jump or branch
	always_comb
	begin
		if (prevCtl)
			victimEpc = alignedPc - 32'd4;
		else
			victimEpc = alignedPc;
	end

	// BD flag for Cause
	assign inDelaySlot = prevCtl;

endmodule

`default_nettype wire

//--- design/exceptionArbiter.sv
`default_nettype none

module exceptionArbiter
	import cp0RegPkg::*;
	import pipeRetirePkg::*;
(
	input  retireInfo retire,
	input  hwIntVec   hwInt,
	input  wire       exl,
	output logic      take,
	output excCode    code
);

	//////////////////////////////////////////////////////////////////////
	// Request sources
	//////////////////////////////////////////////////////////////////////

	// Any interrupt line raised
	logic intReq;

	// Retiring instruction reports an error
	logic errReq;

	assign intReq = |hwInt;

	// Bubble err bits are ignored
	assign errReq = retire.valid && retire.err;

	//////////////////////////////////////////////////////////////////////
	// Priority
	//////////////////////////////////////////////////////////////////////

	// No nesting
	// EXL set blocks everything until eret
	assign take = !exl && (intReq || errReq);

	// Interrupts ahead of instruction errors
	always_comb
	begin
		if (intReq)
		begin
			code = intExc;
		end
		else if (errReq)
		begin
			// Pipeline code goes straight into Cause
			code = retire.errCode;
		end
		else
		begin
			// Nothing pending
			code = noExc;
		end
	end

endmodule

`default_nettype wire

//--- design/cp0ApbPort.sv
`default_nettype none

module cp0ApbPort
	import cp0RegPkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  wire       psel,
	input  wire       penable,
	input  wire       pwrite,
	input  cp0RegAddr paddr,
	input  cp0Word    pwdata,
	output cp0Word    prdata,
	output logic      pready,
	output logic      pslverr,
	output cp0Write   wr,
	output cp0RegAddr rdAddr,
	input  cp0Word    rdData,
	input  wire       excTaken
);

	//////////////////////////////////////////////////////////////////////
	// Phase tracking
	//////////////////////////////////////////////////////////////////////

	// A setup phase was seen on the previous cycle
	logic setupSeen;
	logic access;

	// Address decode
	logic rdOk;
	logic wrOk;

	always_ff @(posedge clk)
	begin
		if (reset)
			setupSeen <= 1'b0;
		else
			setupSeen <= psel && !penable;
	end

	// Access phase only counts after a proper setup
	assign access = psel && penable && setupSeen;

	// No wait states
	assign pready = psel && penable;

	//////////////////////////////////////////////////////////////////////
	// Decode and response
	//////////////////////////////////////////////////////////////////////

	assign rdOk = (paddr >= cp0RegAddr'(srReg)) && (paddr <= cp0RegAddr'(pridReg));

	// Only SR and EPC are writable
	assign wrOk = (paddr == cp0RegAddr'(srReg)) || (paddr == cp0RegAddr'(epcReg));

	// Exception owns the bank in its cycle so the write is lost
	assign wr.valid = access && pwrite && wrOk && !excTaken;
	assign wr.addr  = paddr;
	assign wr.data  = pwdata;

	// Read path straight to the bank mux
	assign rdAddr = paddr;
	assign prdata = (access && !pwrite && rdOk) ? rdData : '0;

	always_comb
	begin
		if (!access)
			pslverr = 1'b0;
		else if (pwrite)
			pslverr = !wrOk || excTaken;
		else
			pslverr = !rdOk;
	end

endmodule

`default_nettype wire

//--- design/cp0RegBank.sv
`include "cp0_settings.svh"

`default_nettype none

module cp0RegBank
	import cp0RegPkg::*;
	import pipeRetirePkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  excRequest exc,
	input  wire       eret,
	input  hwIntVec   hwInt,
	input  cp0Write   wr,
	input  cp0RegAddr rdAddr,
	output cp0Word    rdData,
	output logic      exl,
	output redirect   redir
);

	//////////////////////////////////////////////////////////////////////
	// Architectural registers
	//////////////////////////////////////////////////////////////////////

	cp0Word sr;
	cp0Word cause;
	cp0Word epc;
	cp0Word prid;

	// Eret accepted this cycle
	logic eretNow;

	// Eret target held for one cycle
	redirect eretRedir;

	// Exception wins over eret
	assign eretNow = eret && !exc.take;

	// Priority is exception then eret then bus write
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sr    <= `CP0_SR_RESET;
			cause <= '0;
			epc   <= '0;
			prid  <= `CP0_PRID;
		end
		else if (exc.take)
		begin
			// Set EXL and keep IE
			sr    <= {sr[31:2], 1'b1, sr[0]};
			cause <= {exc.bd, 15'b0, hwInt, 3'b0, exc.code, 2'b00};
			epc   <= exc.epc;
		end
		else if (eretNow)
		begin
			sr <= {sr[31:2], 1'b0, sr[0]};
		end
		else if (wr.valid)
		begin
			// Port only lets SR and EPC through
			case (wr.addr)
				cp0RegAddr'(srReg): sr <= wr.data;
				cp0RegAddr'(epcReg): epc <= wr.data;
				default: ;
			endcase
		end
	end

	assign exl = sr[1];

	//////////////////////////////////////////////////////////////////////
	// Redirect to fetch
	//////////////////////////////////////////////////////////////////////

	// Eret goes out one cycle after EXL clears
	// Handler vector goes out at the next edge
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			eretRedir.valid <= 1'b0;
			redir.valid     <= 1'b0;
		end
		else
		begin
			eretRedir.valid <= eretNow;
			eretRedir.pc    <= epc;
			if (exc.take)
			begin
				redir.valid <= 1'b1;
				redir.pc    <= `CP0_EXC_VECTOR;
			end
			else
			begin
				redir <= eretRedir;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (rdAddr)
			cp0RegAddr'(srReg): rdData = sr;
			cp0RegAddr'(causeReg): rdData = cause;
			cp0RegAddr'(epcReg): rdData = epc;
			cp0RegAddr'(pridReg): rdData = prid;
			// Unmapped numbers read as zero
			default: rdData = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/cp0Unit.sv
`default_nettype none

module cp0Unit
	import cp0RegPkg::*;
	import pipeRetirePkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  retireInfo retire,
	input  hwIntVec   hwInt,
	input  wire       psel,
	input  wire       penable,
	input  wire       pwrite,
	input  cp0RegAddr paddr,
	input  cp0Word    pwdata,
	output cp0Word    prdata,
	output logic      pready,
	output logic      pslverr,
	output redirect   redir
);

	//////////////////////////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////////////////////////

	virtAddr   victimEpc;
	logic      inDelaySlot;
	logic      take;
	excCode    code;
	logic      exl;
	logic      eret;
	excRequest excReq;
	cp0Write   wr;
	cp0RegAddr rdAddr;
	cp0Word    rdData;

	// Bank sorts out a collision with an exception
	assign eret = retire.valid && (retire.cls == eretOp);

	// Decision and victim info travel together
	assign excReq = '{take: take, code: code, epc: victimEpc, bd: inDelaySlot};

	delaySlotTracker i_delaySlotTracker (.clk(clk), .reset(reset), .retire(retire),
		.victimEpc(victimEpc), .inDelaySlot(inDelaySlot));

	exceptionArbiter i_exceptionArbiter (.retire(retire), .hwInt(hwInt), .exl(exl),
		.take(take), .code(code));

	cp0ApbPort i_cp0ApbPort (.clk(clk), .reset(reset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .wr(wr), .rdAddr(rdAddr), .rdData(rdData), .excTaken(take));

	cp0RegBank i_cp0RegBank (.clk(clk), .reset(reset), .exc(excReq), .eret(eret),
		.hwInt(hwInt), .wr(wr), .rdAddr(rdAddr), .rdData(rdData), .exl(exl), .redir(redir));

endmodule

`default_nettype wire

//--- testbench/cp0UnitTests.svh
`ifndef CP0_UNIT_TESTS_SVH
`define CP0_UNIT_TESTS_SVH

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	logic   modelPrevCtl;
	cp0Word modelSr;
	cp0Word modelCause;
	cp0Word modelEpc;

	// Aligned pc, one instruction back when in a delay slot
	function automatic cp0Word victimPc(input virtAddr pc, input logic afterCtl);
		cp0Word aligned;
		aligned = pc & 32'hffff_fffc;
		return afterCtl ? aligned - 32'd4 : aligned;
	endfunction

	// BD at 31, IP at 15:10, ExcCode at 6:2
	function automatic cp0Word causeWord(input logic bd, input hwIntVec hw, input logic [4:0] code);
		cp0Word w;
		w = '0;
		w[31] = bd;
		w[15:10] = hw;
		w[6:2] = code;
		return w;
	endfunction

	// Interrupts beat the instruction error
	function automatic logic [4:0] winningCode(input hwIntVec hw, input excCode errCode);
		return (hw != '0) ? 5'd0 : errCode;
	endfunction

	task automatic predictRetire(input virtAddr pc, input instrClass cls, input logic err,
		input excCode code, input hwIntVec hw, output logic taken);
		taken = !modelSr[1] && (err || (hw != '0));
		if (taken)
		begin
			modelEpc = victimPc(pc, modelPrevCtl);
			modelCause = causeWord(modelPrevCtl, hw, winningCode(hw, code));
			modelSr[1] = 1'b1;
		end
		else if (cls == eretOp)
			modelSr[1] = 1'b0;
		modelPrevCtl = (cls == jumpOp) || (cls == branchOp);
	endtask

	task automatic retireAndCheck(input string testName, input virtAddr pc, input instrClass cls,
		input logic err, input excCode code, input hwIntVec hw);
		logic taken;
		virtAddr target;
		predictRetire(pc, cls, err, code, hw, taken);
		driveRetire(pc, cls, err, code, hw);
		if (taken)
		begin
			// Vector out at the edge that takes the exception
			waitRedirect(testName, 0, target);
			checkValue({testName, " vector"}, `CP0_EXC_VECTOR, target);
		end
		else if (cls == eretOp)
		begin
			// EXL clears first, EPC goes out one edge later
			waitRedirect(testName, 1, target);
			checkValue({testName, " eret target"}, modelEpc, target);
		end
		else
			expectNoRedirect(3);
	endtask

	task automatic compareRegs(input string testName);
		readReg(srReg, modelSr, {testName, " SR"});
		readReg(causeReg, modelCause, {testName, " Cause"});
		readReg(epcReg, modelEpc, {testName, " EPC"});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic resetValues();
		cp0Word rd;
		logic err;
		modelPrevCtl = 1'b0;
		modelSr = `CP0_SR_RESET;
		modelCause = '0;
		modelEpc = '0;
		readReg(srReg, `CP0_SR_RESET, "resetValues SR");
		readReg(causeReg, 32'd0, "resetValues Cause");
		readReg(epcReg, 32'd0, "resetValues EPC");
		readReg(pridReg, `CP0_PRID, "resetValues PRId");
		// Hole in the register map
		apbTransfer(5'd3, 1'b0, '0, rd, err);
		checkValue("resetValues unmapped data", 32'd0, rd);
		checkValue("resetValues unmapped pslverr", 32'd1, 32'(err));
	endtask

	task automatic registerAccess();
		cp0Word d;
		d = $random(seed);
		// EXL stays clear so exceptions can still be taken
		d[1] = 1'b0;
		writeReg(srReg, d, 1'b0, "registerAccess SR write");
		modelSr = d;
		readReg(srReg, modelSr, "registerAccess SR");
		d = $random(seed);
		writeReg(epcReg, d, 1'b0, "registerAccess EPC write");
		modelEpc = d;
		readReg(epcReg, modelEpc, "registerAccess EPC");
		// Read-only registers keep their value
		writeReg(causeReg, 32'hffff_ffff, 1'b1, "registerAccess Cause write");
		readReg(causeReg, modelCause, "registerAccess Cause");
		writeReg(pridReg, 32'h1234_5678, 1'b1, "registerAccess PRId write");
		readReg(pridReg, `CP0_PRID, "registerAccess PRId");
	endtask

	task automatic errorException();
		retireAndCheck("errorException", 32'h1000_0402, plainOp, 1'b1, ovExc, '0);
		compareRegs("errorException");
		// Code 12 in 6:2, BD clear
		readReg(causeReg, 32'h0000_0030, "errorException Cause value");
		readReg(epcReg, 32'h1000_0400, "errorException EPC value");
		// Leave the handler through mtc0
		modelSr[1] = 1'b0;
		writeReg(srReg, modelSr, 1'b0, "errorException SR write");
	endtask

	task automatic delaySlotPriority();
		cp0Word r;
		hwIntVec hw;
		r = $random(seed);
		hw = r[5:0] | 6'b000001;
		retireAndCheck("delaySlot branch", 32'h2000_0100, branchOp, 1'b0, noExc, '0);
		retireAndCheck("delaySlot victim", 32'h2000_0106, plainOp, 1'b1, riExc, hw);
		compareRegs("delaySlot");
		// Victim restarts at the branch
		readReg(epcReg, 32'h2000_0100, "delaySlot EPC value");
		// EXL set, nothing gets through
		retireAndCheck("delaySlot blocked", 32'h2000_0200, jumpOp, 1'b1, sysExc, 6'h3f);
		compareRegs("delaySlot blocked");
	endtask

	task automatic eretReturn();
		retireAndCheck("eretReturn", 32'h0000_4200, eretOp, 1'b0, noExc, '0);
		compareRegs("eretReturn");
	endtask

	task automatic randomRounds();
		cp0Word r;
		virtAddr pc;
		instrClass cls;
		hwIntVec hw;
		excCode codes[4];
		int round;
		codes = '{adelExc, sysExc, riExc, ovExc};
		for (round = 0; round < 24; round++)
		begin
			r = $random(seed);
			pc = $random(seed);
			cls = instrClass'(r[1:0]);
			// Eret only closes a round
			if (cls == eretOp)
				cls = plainOp;
			hw = (r[9:8] == 2'b11) ? r[15:10] : 6'd0;
			retireAndCheck("randomRounds retire", pc, cls, r[2], codes[r[17:16]], hw);
			if (modelSr[1])
			begin
				compareRegs("randomRounds exception");
				pc = $random(seed);
				retireAndCheck("randomRounds eret", pc, eretOp, 1'b0, noExc, '0);
				compareRegs("randomRounds eret");
			end
		end
	endtask

`endif

//--- testbench/cp0UnitTb.sv
`include "cp0_settings.svh"

`default_nettype none

module cp0UnitTb
	import cp0RegPkg::*;
	import pipeRetirePkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_HALF = 50;
	localparam int SAMPLE_DELAY = 25;
	localparam int TIMEOUT_CYCLES = 20;

	logic      clk;
	logic      reset;
	retireInfo retire;
	hwIntVec   hwInt;
	logic      psel;
	logic      penable;
	logic      pwrite;
	cp0RegAddr paddr;
	cp0Word    pwdata;
	cp0Word    prdata;
	logic      pready;
	logic      pslverr;
	redirect   redir;
	integer    seed;

	cp0Unit i_cp0Unit (.clk(clk), .reset(reset), .retire(retire), .hwInt(hwInt),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .redir(redir));

	// 100 ns period
	always #(CLK_HALF) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string testName, input cp0Word expected, input cp0Word actual);
		if (expected !== actual)
		begin
			$display("error: %s expected %h actual %h", testName, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic timeoutFail(input string what);
		$display("timeout: no %s within %0d cycles", what, TIMEOUT_CYCLES);
		$display("Checks failed");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// APB master
	//////////////////////////////////////////////////////////////////////

	// Setup then access, starting and ending on a falling edge
	task automatic apbTransfer(input cp0RegAddr addr, input logic write, input cp0Word wdata,
		output cp0Word rdata, output logic err);
		int n;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		n = 0;
		#(SAMPLE_DELAY);
		while (!pready && n < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			#(SAMPLE_DELAY);
			n++;
		end
		if (!pready)
			timeoutFail("pready");
		// Access phase completes without wait states
		checkValue("apb wait states", 32'd0, 32'(n));
		rdata = prdata;
		err = pslverr;
		// Write lands on the edge in between
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic readReg(input cp0RegAddr addr, input cp0Word expected, input string testName);
		cp0Word rd;
		logic err;
		apbTransfer(addr, 1'b0, '0, rd, err);
		checkValue(testName, expected, rd);
		checkValue({testName, " pslverr"}, 32'd0, 32'(err));
	endtask

	task automatic writeReg(input cp0RegAddr addr, input cp0Word data, input logic expectErr,
		input string testName);
		cp0Word rd;
		logic err;
		apbTransfer(addr, 1'b1, data, rd, err);
		checkValue({testName, " pslverr"}, 32'(expectErr), 32'(err));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Retire side
	//////////////////////////////////////////////////////////////////////

	// One retiring instruction for one cycle, then a bubble
	task automatic driveRetire(input virtAddr pc, input instrClass cls, input logic err,
		input excCode code, input hwIntVec hw);
		retire.valid = 1'b1;
		retire.pc = pc;
		retire.cls = cls;
		retire.err = err;
		retire.errCode = code;
		hwInt = hw;
		@(negedge clk);
		retire = '0;
		hwInt = '0;
	endtask

	// Latency counts falling edges after the retire bubble starts
	task automatic waitRedirect(input string testName, input int latency, output virtAddr target);
		int n;
		n = 0;
		while (!redir.valid && n < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			n++;
		end
		if (!redir.valid)
			timeoutFail("redirect valid");
		checkValue({testName, " redirect latency"}, 32'(latency), 32'(n));
		target = redir.pc;
		// Pulse lasts one cycle only
		@(negedge clk);
		checkValue("redirect pulse width", 32'd0, 32'(redir.valid));
	endtask

	task automatic expectNoRedirect(input int cycles);
		int n;
		for (n = 0; n < cycles; n++)
		begin
			checkValue("unexpected redirect", 32'd0, 32'(redir.valid));
			@(negedge clk);
		end
	endtask

	`include "cp0UnitTests.svh"

	//////////////////////////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		retire = '0;
		hwInt = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		seed = 32'hc960dd00;
		// Two reset cycles
		repeat (2) @(negedge clk);
		reset = 1'b0;
		resetValues();
		registerAccess();
		errorException();
		delaySlotPriority();
		eretReturn();
		randomRounds();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
+incdir+testbench
design/cp0RegPkg.sv
design/pipeRetirePkg.sv
design/delaySlotTracker.sv
design/exceptionArbiter.sv
design/cp0ApbPort.sv
design/cp0RegBank.sv
design/cp0Unit.sv
testbench/cp0UnitTb.sv

//--- Makefile
# Verilator flow for the CP0 unit testbench
VERILATOR ?= verilator
TOP       ?= cp0UnitTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# The pass line in the log decides the result
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
